//--- common/ifu_params.svh
// fetch unit sizing macros; include wherever widths, reset PC or buffer depth are needed
`ifndef IFU_PARAMS_SVH
`define IFU_PARAMS_SVH

// instruction address width in bits
`define INST_ADDR_WIDTH 32

// first PC out of reset, must be 8-byte aligned
// (doubleword boundary so the first fetch covers both slots)
`define PC_RESET_ADDR 32'h8000_0000

// fetch buffer entries, power of two
// also the credit limit of requests in flight plus buffered words
`define FBUF_DEPTH 4

`endif

//--- common/ifu_pkg.sv
// shared fetch types; modules import this package for addresses, instructions and fetch words
`include "ifu_params.svh"

package ifu_pkg;

    // byte address of an instruction
    typedef logic [`INST_ADDR_WIDTH-1:0] inst_addr_t;

    // one rv32 instruction word
    typedef logic [31:0] inst_t;

    // the two instruction slots of a doubleword
    // inst_hi sits at doubleword address + 4
    typedef struct packed {
        inst_t inst_hi;  // bits 63:32
        inst_t inst_lo;  // bits 31:0
    } fetch_slots_t;

    // 64-bit fetch word, written raw by memory and the buffer,
    // read slot by slot by the aligner
    typedef union packed {
        logic [63:0]  raw;    // as returned on the memory port
        fetch_slots_t slots;  // split view
    } fetch_word_u;

endpackage

//--- hw/ifu/ifu_pc_gen.sv
// program counter generator; issues one fetch request per cycle within the credit limit
`timescale 1ns/1ps
`include "ifu_params.svh"

module ifu_pc_gen (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       mem_ready_i,   // memory can take a request
    input  logic                       jump_valid_i,  // redirect strobe from execute
    input  ifu_pkg::inst_addr_t        jump_addr_i,   // redirect target
    input  logic                       rsp_valid_i,   // one response returned
    input  logic [$clog2(`FBUF_DEPTH):0] buf_used_i,  // slots held in fetch buffer
    output logic                       req_valid_o,   // request strobe
    output ifu_pkg::inst_addr_t        req_addr_o     // request address = current pc
);
    import ifu_pkg::*;

    localparam int CNT_W = $clog2(`FBUF_DEPTH) + 1;
    localparam int SUM_W = CNT_W + 1;  // room for the credit sum

    inst_addr_t        pc_q;
    inst_addr_t        pc_step;         // sequential next pc
    inst_addr_t        pc_d;
    logic [CNT_W-1:0]  outstanding_q;   // requests without response yet
    logic [SUM_W-1:0]  credit_sum;
    logic              credit_ok;

    // every request and every buffered word holds one buffer slot
    assign credit_sum = {1'b0, outstanding_q} + {1'b0, buf_used_i};
    assign credit_ok  = credit_sum < SUM_W'(`FBUF_DEPTH);

    // no request in the jump cycle, the pc is still on the old path
    assign req_valid_o = mem_ready_i && !jump_valid_i && credit_ok;
    assign req_addr_o  = pc_q;

    // upper slot only when bit 2 is set, so just four bytes on
    assign pc_step = pc_q[2] ? (pc_q + inst_addr_t'(4)) : (pc_q + inst_addr_t'(8));

    always_comb begin
        if (jump_valid_i) begin
            pc_d = jump_addr_i;  // redirect wins
        end else if (req_valid_o) begin
            pc_d = pc_step;
        end else begin
            pc_d = pc_q;  // hold while not ready or out of credit
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= `PC_RESET_ADDR;
        end else begin
            pc_q <= pc_d;
        end
    end

    // in-flight counter, up per request, down per response
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            outstanding_q <= '0;
        end else begin
            case ({req_valid_o, rsp_valid_i})
                2'b10:   outstanding_q <= outstanding_q + CNT_W'(1);
                2'b01:   outstanding_q <= outstanding_q - CNT_W'(1);
                default: outstanding_q <= outstanding_q;  // none or both
            endcase
        end
    end

    // jump targets from execute must keep word alignment
    a_req_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid_o |-> (req_addr_o[1:0] == 2'b00))
        else $error("fetch request address not 4-byte aligned");

    // memory must not answer more than was asked
    a_rsp_expected: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid_i |-> (outstanding_q != '0))
        else $error("response without outstanding request");

    a_credit_limit: assert property (@(posedge clk) disable iff (!rst_n)
        outstanding_q <= CNT_W'(`FBUF_DEPTH))
        else $error("outstanding requests above buffer depth");

endmodule

//--- hw/ifu/ifu_fetch_buf.sv
// fetch buffer; circular FIFO of returned doublewords and addresses, emptied by a jump flush
`timescale 1ns/1ps
`include "ifu_params.svh"

module ifu_fetch_buf (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         flush_i,     // jump, drop all entries
    input  logic                         wr_valid_i,  // memory response strobe
    input  ifu_pkg::inst_addr_t          wr_addr_i,   // address the response belongs to
    input  ifu_pkg::fetch_word_u         wr_data_i,
    input  logic                         rd_pop_i,    // aligner done with head
    output logic                         rd_valid_o,  // head entry present
    output ifu_pkg::inst_addr_t          rd_addr_o,
    output ifu_pkg::fetch_word_u         rd_data_o,
    output logic [$clog2(`FBUF_DEPTH):0] used_o       // slot count for credits
);
    import ifu_pkg::*;

    localparam int DEPTH = `FBUF_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;

    // storage, payload only
    inst_addr_t        addr_q [DEPTH];
    logic [63:0]       data_q [DEPTH];

    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    logic [CNT_W-1:0]  count_q;
    logic              do_wr;
    logic              do_rd;
    logic              full;

    // a response landing with the flush is from the old path, drop it too
    assign do_wr = wr_valid_i && !flush_i;
    assign do_rd = rd_pop_i && !flush_i;
    assign full  = (count_q == CNT_W'(DEPTH));

    always_ff @(posedge clk) begin
        if (do_wr) begin
            addr_q[wr_ptr_q] <= wr_addr_i;
            data_q[wr_ptr_q] <= wr_data_i.raw;  // stored as raw doubleword
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr_q <= wr_ptr_q + PTR_W'(1);
            end
            if (do_rd) begin
                rd_ptr_q <= rd_ptr_q + PTR_W'(1);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (flush_i) begin
            count_q <= '0;  // one-cycle empty
        end else begin
            case ({do_wr, do_rd})
                2'b10:   count_q <= count_q + CNT_W'(1);
                2'b01:   count_q <= count_q - CNT_W'(1);
                default: count_q <= count_q;
            endcase
        end
    end

    // head is visible the cycle after the write
    assign rd_valid_o     = (count_q != '0);
    assign rd_addr_o      = addr_q[rd_ptr_q];
    assign rd_data_o.raw  = data_q[rd_ptr_q];
    assign used_o         = count_q;

    // credits in the pc generator keep a slot free for every response
    a_no_wr_full: assert property (@(posedge clk) disable iff (!rst_n)
        wr_valid_i && !flush_i |-> !full)
        else $error("fetch buffer written while full");

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
        rd_pop_i |-> rd_valid_o)
        else $error("fetch buffer popped while empty");

endmodule

//--- hw/ifu/ifu_inst_align.sv
// instruction aligner; splits buffered doublewords into instructions for decode, drops wrong path
`timescale 1ns/1ps
`include "ifu_params.svh"

module ifu_inst_align (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 jump_valid_i,  // redirect strobe
    input  ifu_pkg::inst_addr_t  jump_addr_i,
    input  logic                 dec_stall_i,   // decode hold level
    input  logic                 ent_valid_i,   // buffer head present
    input  ifu_pkg::inst_addr_t  ent_addr_i,
    input  ifu_pkg::fetch_word_u ent_data_i,
    output logic                 ent_pop_o,     // release head entry
    output logic                 inst_valid_o,  // instruction strobe to decode
    output ifu_pkg::inst_t       inst_o,
    output ifu_pkg::inst_addr_t  inst_pc_o
);
    import ifu_pkg::*;

    localparam int AW = `INST_ADDR_WIDTH;

    inst_addr_t exp_pc_q;     // pc of the next instruction to hand out
    logic       out_valid_q;  // output register holds an instruction
    inst_t      out_inst_q;
    inst_addr_t out_pc_q;

    logic       hit;          // head doubleword is the expected one
    logic       can_go;
    logic       fire;         // take one slot this cycle
    inst_t      slot;

    // doubleword compare, bit 2 only picks the slot
    assign hit    = (ent_addr_i[AW-1:3] == exp_pc_q[AW-1:3]);
    assign can_go = ent_valid_i && !dec_stall_i && !jump_valid_i;
    assign fire   = can_go && hit;

    assign slot = exp_pc_q[2] ? ent_data_i.slots.inst_hi
                              : ent_data_i.slots.inst_lo;

    // wrong-path word goes at once, a good one after its upper slot
    assign ent_pop_o = can_go && (!hit || exp_pc_q[2]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_pc_q    <= `PC_RESET_ADDR;
            out_valid_q <= 1'b0;
        end else if (jump_valid_i) begin
            exp_pc_q    <= jump_addr_i;  // realign on target
            out_valid_q <= 1'b0;         // pending word is old path
        end else if (!dec_stall_i) begin
            out_valid_q <= fire;         // consumed, reload
            if (fire) begin
                exp_pc_q <= exp_pc_q + inst_addr_t'(4);
            end
        end
        // stalled: everything holds
    end

    // payload, no reset
    always_ff @(posedge clk) begin
        if (fire) begin
            out_inst_q <= slot;
            out_pc_q   <= exp_pc_q;
        end
    end

    // held instruction reappears once the stall drops
    assign inst_valid_o = out_valid_q && !dec_stall_i;
    assign inst_o       = out_inst_q;
    assign inst_pc_o    = out_pc_q;

    a_quiet_in_stall: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(inst_valid_o) |-> !dec_stall_i)
        else $error("instruction issued during decode stall");

    // nothing moves at the output while decode holds
    a_hold_in_stall: assert property (@(posedge clk) disable iff (!rst_n)
        dec_stall_i && !jump_valid_i |=> $stable(inst_pc_o) && $stable(inst_o))
        else $error("aligner output changed during decode stall");

endmodule

//--- hw/ifu_top.sv
// fetch unit top; wires pc generator, fetch buffer and aligner to the memory and decode ports
`timescale 1ns/1ps
`include "ifu_params.svh"

module ifu_top (
    input  logic                 clk,
    input  logic                 rst_n,
    // instruction memory
    input  logic                 mem_ready_i,
    output logic                 mem_req_valid_o,
    output ifu_pkg::inst_addr_t  mem_req_addr_o,
    input  logic                 mem_rsp_valid_i,
    input  ifu_pkg::inst_addr_t  mem_rsp_addr_i,
    input  ifu_pkg::fetch_word_u mem_rsp_data_i,
    // execute redirect
    input  logic                 jump_valid_i,
    input  ifu_pkg::inst_addr_t  jump_addr_i,
    // decode
    input  logic                 dec_stall_i,
    output logic                 inst_valid_o,
    output ifu_pkg::inst_t       inst_o,
    output ifu_pkg::inst_addr_t  inst_pc_o
);
    import ifu_pkg::*;

    logic [$clog2(`FBUF_DEPTH):0] buf_used;  // feeds the credit check
    logic                         ent_pop;
    logic                         ent_valid;
    inst_addr_t                   ent_addr;
    fetch_word_u                  ent_data;

    ifu_pc_gen u_pc_gen (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_ready_i  (mem_ready_i),
        .jump_valid_i (jump_valid_i),
        .jump_addr_i  (jump_addr_i),
        .rsp_valid_i  (mem_rsp_valid_i),  // returns a credit
        .buf_used_i   (buf_used),
        .req_valid_o  (mem_req_valid_o),
        .req_addr_o   (mem_req_addr_o)
    );

    // every response is written, no back-pressure
    ifu_fetch_buf u_fetch_buf (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush_i    (jump_valid_i),
        .wr_valid_i (mem_rsp_valid_i),
        .wr_addr_i  (mem_rsp_addr_i),
        .wr_data_i  (mem_rsp_data_i),
        .rd_pop_i   (ent_pop),
        .rd_valid_o (ent_valid),
        .rd_addr_o  (ent_addr),
        .rd_data_o  (ent_data),
        .used_o     (buf_used)
    );

    ifu_inst_align u_inst_align (
        .clk          (clk),
        .rst_n        (rst_n),
        .jump_valid_i (jump_valid_i),
        .jump_addr_i  (jump_addr_i),
        .dec_stall_i  (dec_stall_i),
        .ent_valid_i  (ent_valid),
        .ent_addr_i   (ent_addr),
        .ent_data_i   (ent_data),
        .ent_pop_o    (ent_pop),
        .inst_valid_o (inst_valid_o),
        .inst_o       (inst_o),
        .inst_pc_o    (inst_pc_o)
    );

endmodule

//--- testbench/tb_imem_model.sv
// instruction memory model for the fetch testbench; answers requests in order after random latency
`timescale 1ns/1ps

module tb_imem_model #(
    parameter int          SEED = 1,
    parameter logic [31:0] KEY  = 32'h0  // xor constant of the pattern rule
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req_valid_i,
    input  ifu_pkg::inst_addr_t  req_addr_i,
    output logic                 rsp_valid_o,
    output ifu_pkg::inst_addr_t  rsp_addr_o,
    output ifu_pkg::fetch_word_u rsp_data_o
);
    import ifu_pkg::*;

    integer     seed;
    int         cycle;
    int         last_due;     // keeps responses one per cycle and in order
    int         lat;
    int         due;
    inst_addr_t addr_q[$];    // pending request addresses
    int         due_q[$];     // cycle each response may go out
    inst_addr_t rsp_a;
    inst_addr_t dw_a;

    initial begin
        seed        = SEED;
        cycle       = 0;
        last_due    = 0;
        rsp_valid_o = 1'b0;
        rsp_addr_o  = '0;
        rsp_data_o  = '0;
    end

    // take requests on the rising edge
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (!rst_n) begin
            addr_q.delete();
            due_q.delete();
            last_due = cycle;
        end else if (req_valid_i) begin
            lat = 1 + int'($unsigned($random(seed)) % 4);  // 1 to 4 cycles
            due = cycle + lat - 1;
            if (due <= last_due) begin
                due = last_due + 1;
            end
            addr_q.push_back(req_addr_i);
            due_q.push_back(due);
            last_due = due;
        end
    end

    // drive responses on the falling edge
    always @(negedge clk) begin
        if (rst_n && addr_q.size() > 0 && due_q[0] <= cycle) begin
            rsp_a = addr_q.pop_front();
            void'(due_q.pop_front());
            dw_a  = {rsp_a[31:3], 3'b000};  // data belongs to the doubleword
            rsp_valid_o                = 1'b1;
            rsp_addr_o                 = rsp_a;
            rsp_data_o.slots.inst_hi   = (dw_a + 32'd4) ^ KEY;
            rsp_data_o.slots.inst_lo   = dw_a ^ KEY;
        end else begin
            rsp_valid_o = 1'b0;
        end
    end

endmodule

//--- testbench/tb_ifu_top.sv
// testbench for the fetch unit top; directed tests over reset, jumps, stalls and memory ready
`timescale 1ns/1ps
`include "ifu_params.svh"

module tb_ifu_top;
    import ifu_pkg::*;

    localparam logic [31:0] KEY     = 32'h5a3c_96e1;  // pattern xor constant
    localparam int          SEED    = 8;
    localparam int          TIMEOUT = 200;            // cycles per wait

    logic        clk;
    logic        rst_n;
    logic        mem_ready;
    logic        mem_req_valid;
    inst_addr_t  mem_req_addr;
    logic        mem_rsp_valid;
    inst_addr_t  mem_rsp_addr;
    fetch_word_u mem_rsp_data;
    logic        jump_valid;
    inst_addr_t  jump_addr;
    logic        dec_stall;
    logic        inst_valid;
    inst_t       inst;
    inst_addr_t  inst_pc;

    integer      seed;
    int          errors;
    int          checks;
    inst_addr_t  exp_pc;        // pc the next instruction must carry
    inst_addr_t  pc_q[$];       // captured decode stream
    inst_t       inst_q[$];

    int          stall_hits = 0;  // strobes seen while decode stalled
    int          req_cnt    = 0;  // requests seen on the memory port
    int          inst_cnt   = 0;  // instructions seen on the decode port
    int          req_base;        // counts at the last jump
    int          inst_base;

    ifu_top DUT (
        .clk(clk), .rst_n(rst_n),
        .mem_ready_i(mem_ready), .mem_req_valid_o(mem_req_valid),
        .mem_req_addr_o(mem_req_addr), .mem_rsp_valid_i(mem_rsp_valid),
        .mem_rsp_addr_i(mem_rsp_addr), .mem_rsp_data_i(mem_rsp_data),
        .jump_valid_i(jump_valid), .jump_addr_i(jump_addr),
        .dec_stall_i(dec_stall), .inst_valid_o(inst_valid),
        .inst_o(inst), .inst_pc_o(inst_pc)
    );

    tb_imem_model #(.SEED(SEED), .KEY(KEY)) u_imem (
        .clk(clk), .rst_n(rst_n),
        .req_valid_i(mem_req_valid), .req_addr_i(mem_req_addr),
        .rsp_valid_o(mem_rsp_valid), .rsp_addr_o(mem_rsp_addr),
        .rsp_data_o(mem_rsp_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // memory and decode side monitor
    always @(posedge clk) begin
        if (rst_n && mem_req_valid) begin
            req_cnt = req_cnt + 1;
        end
        if (rst_n && inst_valid) begin
            pc_q.push_back(inst_pc);
            inst_q.push_back(inst);
            inst_cnt = inst_cnt + 1;
            if (dec_stall) begin
                stall_hits = stall_hits + 1;
                $display("[FAIL] %0t: instruction strobe while decode stalled", $time);
            end
        end
    end

    // word at doubleword A: upper is (A+4)^KEY, lower is A^KEY
    function automatic inst_t expected_inst(input inst_addr_t pc);
        inst_addr_t dw;
        dw = {pc[31:3], 3'b000};
        return pc[2] ? ((dw + 32'd4) ^ KEY) : (dw ^ KEY);
    endfunction

    task automatic check_inst(input string what, input inst_t got, input inst_t exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input string what, input inst_addr_t got, input inst_addr_t exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("[FAIL] %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        checks = checks + 1;
        if (got != exp) begin
            errors = errors + 1;
            $display("[FAIL] %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    // a wait that never ends stops the run
    task automatic abort_on_timeout(input string what);
        errors = errors + 1;
        $display("timeout: %s within %0d cycles", what, TIMEOUT);
        $display("Test failures found");
        $finish;
    endtask

    // pull one instruction off the stream and compare it with the expected pc
    task automatic expect_next();
        int         waited;
        inst_addr_t pc;
        inst_t      word;
        waited = 0;
        while (pc_q.size() == 0 && waited < TIMEOUT) begin
            @(negedge clk);  // queue only grows on the rising edge
            waited = waited + 1;
        end
        if (pc_q.size() == 0) begin
            abort_on_timeout($sformatf("no instruction for pc %h", exp_pc));
        end else begin
            pc   = pc_q.pop_front();
            word = inst_q.pop_front();
            check_addr("instruction pc", pc, exp_pc);
            check_inst("instruction word", word, expected_inst(exp_pc));
            exp_pc = exp_pc + 32'd4;
        end
    endtask

    task automatic expect_stream(input int n);
        for (int i = 0; i < n; i++) begin
            expect_next();
        end
    endtask

    task automatic jump_to(input inst_addr_t target);
        int waited;
        @(negedge clk);
        jump_valid = 1'b1;
        jump_addr  = target;
        @(negedge clk);
        jump_valid = 1'b0;
        pc_q.delete();   // anything captured so far is old path
        inst_q.delete();
        req_base  = req_cnt;
        inst_base = inst_cnt;
        exp_pc    = target;
        // first fetch on the new path is the target itself
        waited = 0;
        @(posedge clk);
        while (!mem_req_valid && waited < TIMEOUT) begin
            @(posedge clk);
            waited = waited + 1;
        end
        if (!mem_req_valid) begin
            abort_on_timeout("no fetch request after jump");
        end else begin
            check_addr("first request after jump", mem_req_addr, target);
        end
    endtask

    task automatic test_reset_stream();
        exp_pc = `PC_RESET_ADDR;
        @(posedge clk);  // first cycle out of reset
        check_flag("request in first cycle after reset", mem_req_valid, 1'b1);
        check_addr("first request address", mem_req_addr, `PC_RESET_ADDR);
        expect_stream(16);
    endtask

    task automatic test_jump_aligned();
        jump_to(32'h0000_1000);
        expect_stream(12);
    endtask

    task automatic test_jump_upper();
        jump_to(32'h0000_2024);  // upper slot first, then next doubleword
        expect_stream(12);
    endtask

    task automatic test_decode_stall();
        int len;
        len = 3 + int'($unsigned($random(seed)) % 12);
        expect_stream(4);
        @(negedge clk);
        dec_stall = 1'b1;
        repeat (len) @(negedge clk);  // monitor flags any strobe here
        dec_stall = 1'b0;
        expect_stream(16);
    endtask

    task automatic test_mem_not_ready();
        @(negedge clk);
        mem_ready = 1'b0;
        for (int i = 0; i < 20; i++) begin
            @(posedge clk);
            check_flag("request while memory not ready", mem_req_valid, 1'b0);
        end
        @(negedge clk);
        mem_ready = 1'b1;
        expect_stream(16);
    endtask

    task automatic test_long_run();
        int waited;
        int reqs;
        jump_to(32'h0001_0008);
        for (int i = 0; i < 200; i++) begin
            expect_next();
        end
        // stop fetching and let the words in flight reach decode
        @(negedge clk);
        mem_ready = 1'b0;
        waited    = 0;
        while (inst_cnt - inst_base < 2 * (req_cnt - req_base) && waited < TIMEOUT) begin
            @(negedge clk);
            waited = waited + 1;
        end
        reqs = req_cnt - req_base;  // aligned doublewords, two instructions each
        check_count("instructions for requests since jump", inst_cnt - inst_base, 2 * reqs);
        while (pc_q.size() > 0) begin
            expect_next();
        end
    endtask

    initial begin
        seed       = SEED;
        errors     = 0;
        checks     = 0;
        exp_pc     = `PC_RESET_ADDR;
        req_base   = 0;
        inst_base  = 0;
        rst_n      = 1'b0;
        mem_ready  = 1'b1;
        jump_valid = 1'b0;
        jump_addr  = '0;
        dec_stall  = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_reset_stream();
        test_jump_aligned();
        test_jump_upper();
        test_decode_stall();
        test_mem_not_ready();
        test_long_run();

        errors = errors + stall_hits;
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+common
common/ifu_pkg.sv
hw/ifu/ifu_pc_gen.sv
hw/ifu/ifu_fetch_buf.sv
hw/ifu/ifu_inst_align.sv
hw/ifu_top.sv
testbench/tb_imem_model.sv
testbench/tb_ifu_top.sv

//--- run_sim.sh
#!/bin/sh
# builds the fetch unit testbench with Verilator, runs it and checks the log

set -u

BUILD_LOG=build.log
SIM_LOG=sim.log
SIM_BIN=tb_ifu_top_sim

verilator --binary --timing --top-module tb_ifu_top -f vlog.f -o "$SIM_BIN" > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/"$SIM_BIN" > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed!" "$SIM_LOG"; then
    echo "result: pass"
    exit 0
else
    echo "result: fail"
    exit 1
fi
